//--- cam_motion_top.f
+incdir+hw
hw/cam_motion_pkg.sv
hw/cam_byte_rx.sv
hw/frame_buffer.sv
hw/video_timing.sv
hw/change_detector.sv
hw/display_mux.sv
hw/cam_motion_top.sv
tb/tb_checks.sv
tb/tb_cam_motion.sv

//--- tb/tb_cam_motion.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_motion_cfg.svh"

module tb_cam_motion;

    localparam int NPIX     = `IMG_W * `IMG_H;
    localparam int FRAME    = (`H_TOTAL + 1) * (`V_TOTAL + 1);
    localparam int TIMEOUT  = 7 * FRAME;
    localparam int CNT_MAX  = (1 << `CNT_W) - 1;
    localparam int BAR_HITS = 2 * (`BAR_V_MAX - `BAR_V_MIN + 1) * (`ACT_H_MAX - `ACT_H_MIN + 1);

    logic        dclk = 1'b0;
    logic        rst;
    logic [7:0]  cam_dat;
    logic        cam_href;
    logic        cam_vs;
    logic        hs;
    logic        vs;
    logic [11:0] rgb;

    logic [15:0] img_a [NPIX];
    logic [15:0] img_b [NPIX];
    logic [31:0] lfsr;
    int          exp_diff;      // saturated A vs B class mismatches

    // raster model, same cycle as the DUT counters
    logic [10:0] hc;
    logic [10:0] vc;
    int          fr;
    logic        in_win;
    logic        in_act;
    logic        on_bar;
    logic        win_q;
    int          idx_q;
    logic        exp_hs;
    logic        exp_vs;
    logic [11:0] exp_rgb;
    logic        rgb_en;
    int          img_hits = 0;
    int          bar_hits = 0;
    int          cycles = 0;
    logic        chk_failed;

    always #10 dclk = ~dclk;

    cam_motion_top cam_motion_top_i (
        .dclk     (dclk),
        .rst      (rst),
        .cam_dat  (cam_dat),
        .cam_href (cam_href),
        .cam_vs   (cam_vs),
        .hs       (hs),
        .vs       (vs),
        .rgb      (rgb)
    );

    tb_checks tb_checks_i (
        .dclk    (dclk),
        .rst     (rst),
        .hs      (hs),
        .vs      (vs),
        .rgb     (rgb),
        .exp_hs  (exp_hs),
        .exp_vs  (exp_vs),
        .exp_rgb (exp_rgb),
        .rgb_en  (rgb_en),
        .failed  (chk_failed)
    );

    //////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit, msb first
    task automatic take_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // strict channel order, green on its top 5 bits
    function automatic int hue_order(input logic [15:0] px);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = px[15:11];
        g = px[10:6];
        b = px[4:0];
        if (r > g && g > b)
            return 6;
        if (r > b && b > g)
            return 5;
        if (g > b && b > r)
            return 4;
        if (g > r && r > b)
            return 3;
        if (b > g && g > r)
            return 2;
        if (b > r && r > g)
            return 1;
        return 0;
    endfunction

    function automatic logic [11:0] top_bits(input logic [15:0] px);
        return {px[15:12], px[10:7], px[4:1]};
    endfunction

    // B is A with roughly one pixel in 128 replaced
    task automatic build_images();
        logic [15:0] sel;
        logic [15:0] px;
        int          i;
        int          cnt;
        cnt = 0;
        for (i = 0; i < NPIX; i++)
        begin
            take_bits(16, px);
            img_a[i] = px;
        end
        for (i = 0; i < NPIX; i++)
        begin
            take_bits(7, sel);
            img_b[i] = img_a[i];
            if (sel == 16'd0)
            begin
                take_bits(16, px);
                img_b[i] = px;
            end
            if (hue_order(img_a[i]) != hue_order(img_b[i]))
                cnt = cnt + 1;
        end
        exp_diff = (cnt > CNT_MAX) ? CNT_MAX : cnt;
        $display("image B differs in class at %0d pixels", cnt);
    endtask

    // vs pulse, then one unbroken href burst, high byte first
    task automatic send_image(input logic use_b);
        logic [15:0] px;
        int          i;
        @(posedge dclk);
        cam_vs <= 1'b1;
        @(posedge dclk);
        cam_vs <= 1'b0;
        for (i = 0; i < NPIX; i++)
        begin
            px = use_b ? img_b[i] : img_a[i];
            @(posedge dclk);
            cam_href <= 1'b1;
            cam_dat  <= px[15:8];
            @(posedge dclk);
            cam_dat  <= px[7:0];
        end
        @(posedge dclk);
        cam_href <= 1'b0;
    endtask

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    //////////////////////////////////////////////////
    // expected outputs, one register stage like the DUT outputs

    assign in_win = (hc >= `IMG_H0) && (hc < `IMG_H0 + `IMG_W) &&
                    (vc >= `IMG_V0) && (vc < `IMG_V0 + `IMG_H);
    assign in_act = (hc >= `ACT_H_MIN) && (hc <= `ACT_H_MAX) &&
                    (vc >= `ACT_V_MIN) && (vc <= `ACT_V_MAX);
    assign on_bar = (vc >= `BAR_V_MIN) && (vc <= `BAR_V_MAX);

    always @(posedge dclk)
    begin
        if (rst)
        begin
            hc      <= '0;
            vc      <= '0;
            fr      <= 0;
            exp_hs  <= 1'b0;
            exp_vs  <= 1'b0;
            win_q   <= 1'b0;
            exp_rgb <= '0;
            rgb_en  <= 1'b0;
        end
        else
        begin
            hc <= (hc == `H_TOTAL) ? 11'd0 : hc + 11'd1;
            if (hc == `H_TOTAL)
            begin
                vc <= (vc == `V_TOTAL) ? 11'd0 : vc + 11'd1;
                if (vc == `V_TOTAL)
                    fr <= fr + 1;
            end
            exp_hs <= (hc >= `HS_END);      // low for the 128 cycles after count 0
            exp_vs <= (vc >= `VS_START);
            win_q  <= in_win;
            idx_q  <= (int'(vc) - `IMG_V0) * `IMG_W + (int'(hc) - `IMG_H0);
            rgb_en <= 1'b0;
            if (win_q)
            begin
                exp_rgb <= top_bits(img_a[idx_q]);
                if (fr >= 1 && fr <= 4)
                begin
                    rgb_en   <= 1'b1;
                    img_hits = img_hits + 1;
                end
            end
            else if (!in_act || !on_bar)
            begin
                exp_rgb <= 12'h000;         // blanking or black fill
                rgb_en  <= 1'b1;
            end
            else if (fr == 4 || fr == 5)
            begin
                // reference A in both, image A in 4 and B in 5
                exp_rgb  <= (hc < `BAR_H0 + ((fr == 5) ? exp_diff : 0)) ? 12'hfff : 12'h000;
                rgb_en   <= 1'b1;
                bar_hits = bar_hits + 1;
            end
        end
    end

    always @(posedge chk_failed)
        abort_run();

    always @(posedge dclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // stimulus

    initial
    begin
        rst      = 1'b1;
        cam_dat  = 8'h00;
        cam_href = 1'b0;
        cam_vs   = 1'b0;
        lfsr     = 32'd62;
        build_images();
        repeat (5) @(posedge dclk);
        rst <= 1'b0;
        send_image(1'b0);
        wait (fr == 4 && vc >= `IMG_V0 + `IMG_H);   // window of frame 4 closed
        send_image(1'b1);
        wait (fr == 5 && vc > `BAR_V_MAX);
        @(posedge dclk);
        if (img_hits == 4 * NPIX && bar_hits == BAR_HITS)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("not every check was reached, %0d image and %0d bar cycles",
                     img_hits, bar_hits);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_checks.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checks (
    input  wire logic        dclk,
    input  wire logic        rst,
    input  wire logic        hs,
    input  wire logic        vs,
    input  wire logic [11:0] rgb,
    input  wire logic        exp_hs,
    input  wire logic        exp_vs,
    input  wire logic [11:0] exp_rgb,
    input  wire logic        rgb_en,
    output logic             failed
);

    int err_count = 0;

    assign failed = (err_count != 0);

    //////////////////////////////////////////////////
    // reset behaviour

    a_quiet_in_reset: assert property (
        @(posedge dclk)
        rst |=> (rgb == 12'h000 && !hs && !vs)
    )
    else
    begin
        $display("** Error at %0t ns: hs/vs/rgb = %b/%b/%h in reset, expected 0/0/000",
                 $time, $sampled(hs), $sampled(vs), $sampled(rgb));
        err_count = err_count + 1;
    end

    //////////////////////////////////////////////////
    // sync pulses against the raster model

    a_hs_timing: assert property (
        @(posedge dclk) disable iff (rst)
        hs == exp_hs
    )
    else
    begin
        $display("** Error at %0t ns: hs = %b, expected %b",
                 $time, $sampled(hs), $sampled(exp_hs));
        err_count = err_count + 1;
    end

    a_vs_timing: assert property (
        @(posedge dclk) disable iff (rst)
        vs == exp_vs
    )
    else
    begin
        $display("** Error at %0t ns: vs = %b, expected %b",
                 $time, $sampled(vs), $sampled(exp_vs));
        err_count = err_count + 1;
    end

    // image pixels, bar, black fill and blanking
    a_rgb_value: assert property (
        @(posedge dclk) disable iff (rst)
        rgb_en |-> (rgb == exp_rgb)
    )
    else
    begin
        $display("** Error at %0t ns: rgb = %h, expected %h",
                 $time, $sampled(rgb), $sampled(exp_rgb));
        err_count = err_count + 1;
    end

endmodule

`default_nettype wire

//--- hw/cam_motion_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_motion_cfg.svh"

module cam_motion_top (
    input  wire logic        dclk,
    input  wire logic        rst,
    input  wire logic [7:0]  cam_dat,
    input  wire logic        cam_href,
    input  wire logic        cam_vs,
    output logic             hs,
    output logic             vs,
    output logic [11:0]      rgb
);

    import cam_motion_pkg::*;

    logic              fb_we;
    logic [`FB_AW-1:0] fb_waddr;
    rgb565_u           fb_wdata;
    logic [`FB_AW-1:0] fb_raddr;
    rgb565_u           fb_rdata;
    logic [10:0]       h_count;
    logic              active;
    logic              img_win;
    logic              frame_start;
    logic              bar_row;
    logic              ref_frame;
    logic              pix_valid;
    logic [`CNT_W-1:0] diff_count;

    //////////////////////////////////////////////////
    // camera into the frame buffer

    cam_byte_rx cam_byte_rx_i (
        .dclk     (dclk),
        .rst      (rst),
        .cam_dat  (cam_dat),
        .cam_href (cam_href),
        .cam_vs   (cam_vs),
        .fb_we    (fb_we),
        .fb_waddr (fb_waddr),
        .fb_wdata (fb_wdata)
    );

    frame_buffer frame_buffer_i (
        .dclk  (dclk),
        .we    (fb_we),
        .waddr (fb_waddr),
        .wdata (fb_wdata),
        .raddr (fb_raddr),
        .rdata (fb_rdata)
    );

    //////////////////////////////////////////////////
    // raster, analysis and display

    video_timing video_timing_i (
        .dclk        (dclk),
        .rst         (rst),
        .hs          (hs),
        .vs          (vs),
        .h_count     (h_count),
        .active      (active),
        .img_win     (img_win),
        .frame_start (frame_start),
        .bar_row     (bar_row),
        .ref_frame   (ref_frame)
    );

    change_detector change_detector_i (
        .dclk        (dclk),
        .rst         (rst),
        .frame_start (frame_start),
        .ref_frame   (ref_frame),
        .pix_valid   (pix_valid),
        .fb_rdata    (fb_rdata),
        .diff_count  (diff_count)
    );

    display_mux display_mux_i (
        .dclk        (dclk),
        .rst         (rst),
        .frame_start (frame_start),
        .active      (active),
        .img_win     (img_win),
        .bar_row     (bar_row),
        .h_count     (h_count),
        .diff_count  (diff_count),
        .fb_rdata    (fb_rdata),
        .fb_raddr    (fb_raddr),
        .pix_valid   (pix_valid),
        .rgb         (rgb)
    );

endmodule

`default_nettype wire

//--- hw/display_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_motion_cfg.svh"

module display_mux (
    input  wire logic                    dclk,
    input  wire logic                    rst,
    input  wire logic                    frame_start,
    input  wire logic                    active,
    input  wire logic                    img_win,
    input  wire logic                    bar_row,
    input  wire logic [10:0]             h_count,
    input  wire logic [`CNT_W-1:0]       diff_count,
    input  wire cam_motion_pkg::rgb565_u fb_rdata,
    output logic [`FB_AW-1:0]            fb_raddr,
    output logic                         pix_valid,
    output logic [11:0]                  rgb
);

    logic [10:0] bar_end;

    assign bar_end = 11'(`BAR_H0) + 11'(diff_count);

    //////////////////////////////////////////////////
    // read addressing, one word per window cycle

    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            fb_raddr  <= '0;
            pix_valid <= 1'b0;
        end
        else
        begin
            pix_valid <= img_win;       // RAM data lands one cycle later
            if (frame_start)
                fb_raddr <= '0;
            else if (img_win)
                fb_raddr <= fb_raddr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // colour out

    always_ff @(posedge dclk)
    begin
        if (rst)
            rgb <= '0;
        else if (pix_valid)
            rgb <= {fb_rdata.ch.r[4:1], fb_rdata.ch.g[5:2], fb_rdata.ch.b[4:1]};
        else if (active)
        begin
            if (bar_row && h_count < bar_end)
                rgb <= 12'hfff;
            else
                rgb <= 12'h000;
        end
        else
            rgb <= '0;                  // blanking
    end

endmodule

`default_nettype wire

//--- hw/change_detector.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_motion_cfg.svh"

module change_detector (
    input  wire logic                    dclk,
    input  wire logic                    rst,
    input  wire logic                    frame_start,
    input  wire logic                    ref_frame,
    input  wire logic                    pix_valid,
    input  wire cam_motion_pkg::rgb565_u fb_rdata,
    output logic [`CNT_W-1:0]            diff_count
);

    import cam_motion_pkg::*;

    localparam int FB_DEPTH = `IMG_W * `IMG_H;

    // green compared on its top 5 bits, same scale as r and b
    function automatic hue_class_t classify(input rgb565_u px);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = px.ch.r;
        g = px.ch.g[5:1];
        b = px.ch.b;
        if (r > g && g > b)
            return CLS_RGB;
        else if (r > b && b > g)
            return CLS_RBG;
        else if (g > b && b > r)
            return CLS_GBR;
        else if (g > r && r > b)
            return CLS_GRB;
        else if (b > g && g > r)
            return CLS_BGR;
        else if (b > r && r > g)
            return CLS_BRG;
        else
            return CLS_FLAT;
    endfunction

    hue_class_t        ref_mem [FB_DEPTH];
    hue_class_t        cur_cls;
    hue_class_t        cls_q;       // class of the pixel under compare
    hue_class_t        ref_q;       // stored class, read before write
    logic [`FB_AW-1:0] ptr;
    logic              cmp_valid;

    assign cur_cls = classify(fb_rdata);

    // reference memory, read-first
    always_ff @(posedge dclk)
    begin
        if (pix_valid)
        begin
            ref_q <= ref_mem[ptr];
            cls_q <= cur_cls;
            if (ref_frame)
                ref_mem[ptr] <= cur_cls;
        end
    end

    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            ptr        <= '0;
            cmp_valid  <= 1'b0;
            diff_count <= '0;
        end
        else
        begin
            cmp_valid <= pix_valid;
            if (frame_start)
                ptr <= '0;
            else if (pix_valid)
                ptr <= ptr + 1'b1;
            if (frame_start)
                diff_count <= '0;
            else if (cmp_valid && cls_q != ref_q && diff_count != '1)
                diff_count <= diff_count + 1'b1;   // sticks at full scale
        end
    end

    // window length from the display side must fit the class memory
    a_ptr_in_range: assert property (
        @(posedge dclk) disable iff (rst)
        pix_valid |-> (ptr < FB_DEPTH)
    );

endmodule

`default_nettype wire

//--- hw/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_motion_cfg.svh"

module video_timing (
    input  wire logic        dclk,
    input  wire logic        rst,
    output logic             hs,
    output logic             vs,
    output logic [10:0]      h_count,
    output logic             active,
    output logic             img_win,
    output logic             frame_start,
    output logic             bar_row,
    output logic             ref_frame
);

    localparam int FI_W = (`REF_PERIOD > 1) ? $clog2(`REF_PERIOD) : 1;

    logic [10:0]     v_count;
    logic [FI_W-1:0] frame_idx;

    //////////////////////////////////////////////////
    // raster counters

    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (h_count == `H_TOTAL)
        begin
            h_count <= '0;
            if (v_count == `V_TOTAL)
                v_count <= '0;
            else
                v_count <= v_count + 1'b1;
        end
        else
        begin
            h_count <= h_count + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // syncs and frame index

    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            hs        <= 1'b0;
            vs        <= 1'b0;
            frame_idx <= '0;
        end
        else
        begin
            if (h_count == 0)
                hs <= 1'b0;
            else if (h_count == `HS_END)
                hs <= 1'b1;
            if (v_count == 0)
                vs <= 1'b0;
            else if (v_count == `VS_START)
                vs <= 1'b1;
            if (v_count == `VS_START && h_count == 0)
            begin
                if (frame_idx == FI_W'(`REF_PERIOD - 1))
                    frame_idx <= '0;
                else
                    frame_idx <= frame_idx + 1'b1;
            end
        end
    end

    // region decodes straight off the counters
    assign active = (h_count >= `ACT_H_MIN) && (h_count <= `ACT_H_MAX) &&
                    (v_count >= `ACT_V_MIN) && (v_count <= `ACT_V_MAX);
    assign img_win = (h_count >= `IMG_H0) && (h_count <= `IMG_H0 + `IMG_W - 1) &&
                     (v_count >= `IMG_V0) && (v_count <= `IMG_V0 + `IMG_H - 1);
    assign frame_start = (v_count == `ACT_V_MIN) && (h_count == 0);
    assign bar_row     = (v_count >= `BAR_V_MIN) && (v_count <= `BAR_V_MAX);
    assign ref_frame   = (frame_idx == '0);

    // window must sit inside the visible area
    a_win_in_active: assert property (
        @(posedge dclk) disable iff (rst)
        img_win |-> active
    );

endmodule

`default_nettype wire

//--- hw/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_motion_cfg.svh"

module frame_buffer (
    input  wire logic                    dclk,
    input  wire logic                    we,
    input  wire logic [`FB_AW-1:0]       waddr,
    input  wire cam_motion_pkg::rgb565_u wdata,
    input  wire logic [`FB_AW-1:0]       raddr,
    output cam_motion_pkg::rgb565_u      rdata
);

    import cam_motion_pkg::*;

    localparam int FB_DEPTH = `IMG_W * `IMG_H;

    rgb565_u mem [FB_DEPTH];

    // camera side
    always_ff @(posedge dclk)
    begin
        if (we)
            mem[waddr] <= wdata;
    end

    // display side, one cycle latency
    always_ff @(posedge dclk)
    begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- hw/cam_byte_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_motion_cfg.svh"

module cam_byte_rx (
    input  wire logic                    dclk,
    input  wire logic                    rst,
    input  wire logic [7:0]              cam_dat,
    input  wire logic                    cam_href,
    input  wire logic                    cam_vs,
    output logic                         fb_we,
    output logic [`FB_AW-1:0]            fb_waddr,
    output cam_motion_pkg::rgb565_u      fb_wdata
);

    localparam int FB_DEPTH = `IMG_W * `IMG_H;

    logic       phase;      // 1 on the low byte
    logic [7:0] hi_byte;

    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            phase    <= 1'b0;
            fb_we    <= 1'b0;
            fb_waddr <= '1;
        end
        else
        begin
            fb_we <= 1'b0;
            if (cam_href)
            begin
                phase <= ~phase;
                if (phase)
                begin
                    fb_we    <= 1'b1;
                    fb_waddr <= fb_waddr + 1'b1;
                end
            end
            else
            begin
                phase <= 1'b0;
                if (cam_vs)
                    fb_waddr <= '1;     // next word wraps to 0
            end
        end
    end

    // byte pairing, high byte first
    always_ff @(posedge dclk)
    begin
        if (cam_href && !phase)
            hi_byte <= cam_dat;
        if (cam_href && phase)
            fb_wdata.word <= {hi_byte, cam_dat};
    end

    // camera must not run past one image per vs
    a_wr_in_image: assert property (
        @(posedge dclk) disable iff (rst)
        fb_we |-> (fb_waddr < FB_DEPTH)
    );

endmodule

`default_nettype wire

//--- hw/cam_motion_pkg.sv
`default_nettype none

package cam_motion_pkg;

    // rgb565 channel layout, msb first
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_s;

    // pixel as a raw camera word or as colour fields
    typedef union packed {
        logic [15:0] word;
        rgb565_s     ch;
    } rgb565_u;

    // channel ordering classes, strongest first in the name
    typedef enum logic [2:0] {
        CLS_FLAT = 3'd0,    // no strict ordering
        CLS_BRG  = 3'd1,
        CLS_BGR  = 3'd2,
        CLS_GRB  = 3'd3,
        CLS_GBR  = 3'd4,
        CLS_RBG  = 3'd5,
        CLS_RGB  = 3'd6
    } hue_class_t;

endpackage

`default_nettype wire

//--- hw/cam_motion_cfg.svh
`ifndef CAM_MOTION_CFG_SVH
`define CAM_MOTION_CFG_SVH

// raster, last count of each counter
`define H_TOTAL     1056
`define V_TOTAL     628

// sync edges
`define HS_END      128         // hs back high here
`define VS_START    4           // vs back high on this line

// visible region, inclusive bounds
`define ACT_H_MIN   217
`define ACT_H_MAX   1016
`define ACT_V_MIN   28
`define ACT_V_MAX   626

// camera image window
`define IMG_H0      221
`define IMG_V0      29
`define IMG_W       320
`define IMG_H       240

// difference bar
`define BAR_V_MIN   531
`define BAR_V_MAX   534
`define BAR_H0      220         // left edge, bar grows to the right

// frames between reference captures
`define REF_PERIOD  4

// storage widths
`define FB_AW       17
`define CNT_W       10

`endif
